//--- hw/cachePkg.sv
package cachePkg;

  // cache geometry
  // 64 sets, two ways, 32 byte lines
  localparam int XLEN     = 64;
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 5;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int SETS     = 1 << INDEX_W;
  // 64-bit beats per line
  localparam int BEATS    = (1 << OFFSET_W) / (XLEN / 8);

  // one pipeline word
  typedef logic [XLEN-1:0] wordT;

  // full line, word 0 sits in the low bits
  typedef wordT [BEATS-1:0] lineT;

  typedef logic [TAG_W-1:0] tagT;

  // pipeline read request
  // room for op and byte mask fields later
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } cpuReqT;

  // one read beat from memory
  typedef struct packed {
    wordT data;
    logic last;
  } memBeatT;

  // controller states
  typedef enum logic [2:0] {
    Idle,
    Compare,
    Miss,
    GetData,
    Replace
  } cacheStateT;

endpackage

//--- hw/cacheSram.sv
`timescale 1ns/1ps

// behavioral single port sram
// read data registered, one cycle after the index
module cacheSram #(
  parameter type EntryT = cachePkg::lineT,
  parameter int  Depth  = cachePkg::SETS
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  EntryT                    wdata_i,
  output EntryT                    rdata_o
);

  // storage array, no reset
  EntryT mem [Depth];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        // write cycle leaves rdata_o untouched
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

//--- hw/cacheWay.sv
`timescale 1ns/1ps

// one cache way
// data sram + tag sram, tag compare and word pick
module cacheWay (
  input  logic                           clk,
  input  logic                           rdEn_i,
  input  logic                           we_i,
  input  logic [cachePkg::INDEX_W-1:0]   index_i,
  input  cachePkg::tagT                  reqTag_i,
  input  logic [1:0]                     wordSel_i,
  input  cachePkg::tagT                  wrTag_i,
  input  cachePkg::lineT                 wrLine_i,
  input  logic                           valid_i,
  output logic                           hit_o,
  output cachePkg::wordT                 word_o
);

  logic           sramEn;
  cachePkg::lineT lineQ;
  cachePkg::tagT  tagQ;

  // both arrays share the index and enable
  assign sramEn = rdEn_i | we_i;

  // line storage
  cacheSram #(
    .EntryT (cachePkg::lineT),
    .Depth  (cachePkg::SETS)
  ) u_dataSram (
    .clk     (clk),
    .en_i    (sramEn),
    .we_i    (we_i),
    .addr_i  (index_i),
    .wdata_i (wrLine_i),
    .rdata_o (lineQ)
  );

  // tag storage
  cacheSram #(
    .EntryT (cachePkg::tagT),
    .Depth  (cachePkg::SETS)
  ) u_tagSram (
    .clk     (clk),
    .en_i    (sramEn),
    .we_i    (we_i),
    .addr_i  (index_i),
    .wdata_i (wrTag_i),
    .rdata_o (tagQ)
  );

  // valid bit lives in the controller
  // stored tag only counts when the set entry is valid
  assign hit_o = valid_i & (tagQ == reqTag_i);

  // pick the requested 64-bit word out of the line
  assign word_o = lineQ[wordSel_i];

endmodule

//--- hw/refillBuffer.sv
`timescale 1ns/1ps

// refill line buffer
// gathers four memory beats into one line
module refillBuffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              capture_i,
  input  cachePkg::memBeatT beat_i,
  input  logic              beatValid_i,
  output cachePkg::lineT    line_o,
  output logic              done_o
);

  // slot for the next beat
  logic [1:0] beatCntQ;
  logic       take;

  // beats only count while the controller waits for data
  assign take = capture_i & beatValid_i;

  // last beat closes the burst
  assign done_o = take & beat_i.last;

  // beat counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCntQ <= '0;
    end else if (take) begin
      if (beat_i.last) begin
        // ready for the next refill
        beatCntQ <= '0;
      end else begin
        beatCntQ <= beatCntQ + 2'd1;
      end
    end
  end

  // line payload, beats land in word order
  // held until the next refill so the controller can forward from it
  always_ff @(posedge clk) begin
    if (take) begin
      line_o[beatCntQ] <= beat_i.data;
    end
  end

endmodule

//--- hw/cacheCtrl.sv
`timescale 1ns/1ps

// cache controller
// request latch, fsm, valid and lru bits, sram steering, read data mux
module cacheCtrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cpuValid_i,
  input  cachePkg::cpuReqT              cpuReq_i,
  input  logic [1:0]                    hit_i,
  input  cachePkg::wordT [1:0]          wayWord_i,
  input  cachePkg::lineT                refillLine_i,
  input  logic                          refillDone_i,
  input  logic                          memRdReady_i,
  output logic                          addrOk_o,
  output logic                          dataOk_o,
  output cachePkg::wordT                rdData_o,
  output logic                          memRdValid_o,
  output logic [cachePkg::ADDR_W-1:0]   memAddr_o,
  output logic                          capture_o,
  output logic [cachePkg::INDEX_W-1:0]  rdIndex_o,
  output logic                          rdEn_o,
  output logic [1:0]                    wayWe_o,
  output logic [1:0]                    wayValid_o,
  output cachePkg::tagT                 wrTag_o,
  output logic [1:0]                    wordSel_o
);

  cachePkg::cacheStateT stateQ, stateD;

  // request currently being answered
  cachePkg::cpuReqT reqQ;

  logic [cachePkg::INDEX_W-1:0] reqIdx;
  logic [cachePkg::INDEX_W-1:0] cpuIdx;

  // per way valid vectors, indexed by set
  logic [1:0][cachePkg::SETS-1:0] validQ;
  // most recently used way per set
  logic [cachePkg::SETS-1:0] lruQ;

  // compare cycle right after a fill answers from the refill buffer
  logic fwdQ;
  logic victimQ, victimD;
  logic curHit;
  logic accept;
  logic isIdle, isCompare;

  assign isIdle    = (stateQ == cachePkg::Idle);
  assign isCompare = (stateQ == cachePkg::Compare);

  // address fields of the latched request
  assign reqIdx    = reqQ.addr[cachePkg::OFFSET_W +: cachePkg::INDEX_W];
  assign wrTag_o   = reqQ.addr[cachePkg::ADDR_W-1 -: cachePkg::TAG_W];
  assign wordSel_o = reqQ.addr[cachePkg::OFFSET_W-1 -: 2];

  // set of the incoming request
  assign cpuIdx = cpuReq_i.addr[cachePkg::OFFSET_W +: cachePkg::INDEX_W];

  // forwarded word counts as a hit too
  assign curHit = fwdQ | (|hit_i);

  // pipeline handshake
  assign addrOk_o = isIdle | (isCompare & curHit);
  assign accept   = cpuValid_i & addrOk_o;
  assign dataOk_o = isCompare & curHit;

  // refill word first, then whichever way hit
  always_comb begin
    if (fwdQ) begin
      rdData_o = refillLine_i[wordSel_o];
    end else if (hit_i[1]) begin
      rdData_o = wayWord_i[1];
    end else begin
      rdData_o = wayWord_i[0];
    end
  end

  // memory side, line aligned
  assign memRdValid_o = (stateQ == cachePkg::Miss);
  assign memAddr_o    = {wrTag_o, reqIdx, {cachePkg::OFFSET_W{1'b0}}};
  assign capture_o    = (stateQ == cachePkg::GetData);

  // sram read on accept, else keep the latched set
  // same index serves the write in Replace
  assign rdIndex_o = accept ? cpuIdx : reqIdx;
  assign rdEn_o    = accept;

  // only the victim way gets written
  always_comb begin
    wayWe_o = 2'b00;
    if (stateQ == cachePkg::Replace) begin
      wayWe_o[victimQ] = 1'b1;
    end
  end

  // valid bits for the tag compare
  assign wayValid_o = {validQ[1][reqIdx], validQ[0][reqIdx]};

  // victim pick
  // empty way first, else the one not used last
  always_comb begin
    if (!validQ[0][reqIdx]) begin
      victimD = 1'b0;
    end else if (!validQ[1][reqIdx]) begin
      victimD = 1'b1;
    end else begin
      victimD = ~lruQ[reqIdx];
    end
  end

  // next state
  always_comb begin
    stateD = stateQ;
    unique case (stateQ)
      cachePkg::Idle: begin
        if (cpuValid_i) begin
          stateD = cachePkg::Compare;
        end
      end
      cachePkg::Compare: begin
        if (!curHit) begin
          stateD = cachePkg::Miss;
        end else if (!cpuValid_i) begin
          stateD = cachePkg::Idle;
        end
      end
      cachePkg::Miss: begin
        // address goes out when memory is ready
        if (memRdReady_i) begin
          stateD = cachePkg::GetData;
        end
      end
      cachePkg::GetData: begin
        if (refillDone_i) begin
          stateD = cachePkg::Replace;
        end
      end
      cachePkg::Replace: begin
        stateD = cachePkg::Compare;
      end
      default: begin
        stateD = cachePkg::Idle;
      end
    endcase
  end

  // fsm and miss bookkeeping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ  <= cachePkg::Idle;
      fwdQ    <= 1'b0;
      victimQ <= 1'b0;
    end else begin
      stateQ <= stateD;
      fwdQ   <= (stateQ == cachePkg::Replace);
      // settles while beats arrive
      if (stateQ == cachePkg::GetData) begin
        victimQ <= victimD;
      end
    end
  end

  // request latch
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= cpuReq_i;
    end
  end

  // valid and lru arrays
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      lruQ   <= '0;
    end else if (stateQ == cachePkg::Replace) begin
      // freshly filled way becomes most recent
      validQ[victimQ][reqIdx] <= 1'b1;
      lruQ[reqIdx]            <= victimQ;
    end else if (isCompare && !fwdQ && (|hit_i)) begin
      lruQ[reqIdx] <= hit_i[1];
    end
  end

endmodule

//--- hw/cacheTop.sv
`timescale 1ns/1ps

// two way instruction cache top
module cacheTop (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cpuValid_i,
  input  cachePkg::cpuReqT              cpuReq_i,
  input  logic                          memRdReady_i,
  input  cachePkg::memBeatT             memBeat_i,
  input  logic                          memBeatValid_i,
  output logic                          addrOk_o,
  output logic                          dataOk_o,
  output cachePkg::wordT                rdData_o,
  output logic                          memRdValid_o,
  output logic [cachePkg::ADDR_W-1:0]   memAddr_o
);

  // way side
  logic [1:0]                   hit;
  cachePkg::wordT [1:0]         wayWord;
  logic [1:0]                   wayWe;
  logic [1:0]                   wayValid;
  logic [cachePkg::INDEX_W-1:0] rdIndex;
  logic                         rdEn;
  cachePkg::tagT                wrTag;
  logic [1:0]                   wordSel;

  // refill side
  cachePkg::lineT refillLine;
  logic           refillDone;
  logic           capture;

  cacheCtrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpuValid_i   (cpuValid_i),
    .cpuReq_i     (cpuReq_i),
    .hit_i        (hit),
    .wayWord_i    (wayWord),
    .refillLine_i (refillLine),
    .refillDone_i (refillDone),
    .memRdReady_i (memRdReady_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .memRdValid_o (memRdValid_o),
    .memAddr_o    (memAddr_o),
    .capture_o    (capture),
    .rdIndex_o    (rdIndex),
    .rdEn_o       (rdEn),
    .wayWe_o      (wayWe),
    .wayValid_o   (wayValid),
    .wrTag_o      (wrTag),
    .wordSel_o    (wordSel)
  );

  // two identical ways
  // latched tag serves as compare tag and write tag
  for (genvar w = 0; w < 2; w++) begin : gWay
    cacheWay u_way (
      .clk       (clk),
      .rdEn_i    (rdEn),
      .we_i      (wayWe[w]),
      .index_i   (rdIndex),
      .reqTag_i  (wrTag),
      .wordSel_i (wordSel),
      .wrTag_i   (wrTag),
      .wrLine_i  (refillLine),
      .valid_i   (wayValid[w]),
      .hit_o     (hit[w]),
      .word_o    (wayWord[w])
    );
  end

  refillBuffer u_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .capture_i   (capture),
    .beat_i      (memBeat_i),
    .beatValid_i (memBeatValid_i),
    .line_o      (refillLine),
    .done_o      (refillDone)
  );

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

// testbench clock and reset
// 40 ns period, reset low for three rising edges
module tbClock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // release just after the third edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- dv/tbMemModel.sv
`timescale 1ns/1ps

// burst read memory model
// random ready delay and beat gaps
module tbMemModel (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        memRdValid_i,
  input  logic [cachePkg::ADDR_W-1:0] memAddr_i,
  output logic                        memRdReady_o,
  output cachePkg::memBeatT           memBeat_o,
  output logic                        memBeatValid_o
);

  logic [31:0] lfsr;

  // galois lfsr, one step per random bit
  function automatic int unsigned takeBits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  // memory content: address low, inverted address high
  function automatic cachePkg::wordT memWord(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {~a, a};
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // one line refill
  // address held by the cache for the whole miss
  task automatic serveBurst();
    logic [31:0] base;
    base = memAddr_i;
    repeat (takeBits(2)) nextCycle();
    memRdReady_o = 1'b1;
    nextCycle();
    memRdReady_o = 1'b0;
    for (int b = 0; b < cachePkg::BEATS; b++) begin
      // optional gap before each beat
      if (takeBits(1) != 0) begin
        memBeatValid_o = 1'b0;
        nextCycle();
      end
      memBeat_o.data = memWord(base + b * 8);
      memBeat_o.last = (b == cachePkg::BEATS - 1);
      memBeatValid_o = 1'b1;
      nextCycle();
    end
    memBeatValid_o = 1'b0;
  endtask

  initial begin
    lfsr = 32'h8bad;
    memRdReady_o = 1'b0;
    memBeat_o = '0;
    memBeatValid_o = 1'b0;
    forever begin
      nextCycle();
      if (rst_n && memRdValid_i) begin
        serveBurst();
      end
    end
  end

endmodule

//--- dv/cacheTb.sv
`timescale 1ns/1ps

// icache testbench top
module cacheTb;

  // request count and per request watchdog budget
  localparam int NumReqs = 333;
  localparam int CyclesPerReq = 200;
  localparam int ClkPeriod = 40;

  logic clk;
  logic rst_n;
  logic cpuValid;
  cachePkg::cpuReqT cpuReq;
  logic addrOk;
  logic dataOk;
  cachePkg::wordT rdData;
  logic memRdValid;
  logic [cachePkg::ADDR_W-1:0] memAddr;
  logic memRdReady;
  cachePkg::memBeatT memBeat;
  logic memBeatValid;

  // shadow of tags, valid and lru bits
  cachePkg::tagT tagS [2][cachePkg::SETS];
  logic validS [2][cachePkg::SETS];
  logic lruS [cachePkg::SETS];

  // expected answers and refill lines in issue order
  cachePkg::wordT wordQ [$];
  logic [cachePkg::ADDR_W-1:0] missQ [$];
  logic refilling;
  logic [31:0] lfsr;

  tbClock u_clk (.clk(clk), .rst_n(rst_n));

  cacheTop u_dut (
    .clk(clk), .rst_n(rst_n), .cpuValid_i(cpuValid), .cpuReq_i(cpuReq),
    .memRdReady_i(memRdReady), .memBeat_i(memBeat), .memBeatValid_i(memBeatValid),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .memRdValid_o(memRdValid), .memAddr_o(memAddr)
  );

  tbMemModel u_mem (
    .clk(clk), .rst_n(rst_n), .memRdValid_i(memRdValid), .memAddr_i(memAddr),
    .memRdReady_o(memRdReady), .memBeat_o(memBeat), .memBeatValid_o(memBeatValid)
  );

  // galois lfsr stepped once per bit taken
  function automatic int unsigned takeBits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  // reference word holds the address low and its inverse high
  function automatic cachePkg::wordT expWord(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {~a, a};
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(input cachePkg::wordT got, input cachePkg::wordT exp);
    if (got !== exp) begin
      abortRun($sformatf("FAIL @%0t: read data %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic checkLine(input logic [cachePkg::ADDR_W-1:0] got,
                           input logic [cachePkg::ADDR_W-1:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("FAIL @%0t: refill line %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // shadow lookup for one request
  // a miss fills the empty way first or else the way not used last
  task automatic predict(input logic [31:0] addr);
    cachePkg::tagT tag;
    logic [cachePkg::INDEX_W-1:0] idx;
    int way;
    tag = addr[31 -: cachePkg::TAG_W];
    idx = addr[cachePkg::OFFSET_W +: cachePkg::INDEX_W];
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (validS[w][idx] && tagS[w][idx] == tag) begin
        way = w;
      end
    end
    if (way < 0) begin
      if (!validS[0][idx]) begin
        way = 0;
      end else if (!validS[1][idx]) begin
        way = 1;
      end else begin
        way = lruS[idx] ? 0 : 1;
      end
      validS[way][idx] = 1'b1;
      tagS[way][idx] = tag;
      missQ.push_back({addr[31:cachePkg::OFFSET_W], 5'b00000});
    end
    lruS[idx] = (way == 1);
    wordQ.push_back(expWord(addr));
  endtask

  // hold the request until the cache takes it
  task automatic issue(input logic [31:0] addr);
    predict(addr);
    cpuValid = 1'b1;
    cpuReq.addr = addr;
    while (!addrOk) nextCycle();
    nextCycle();
  endtask

  task automatic drain();
    cpuValid = 1'b0;
    while (wordQ.size() != 0) nextCycle();
  endtask

  // compare at mid cycle where outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (dataOk) begin
        if (wordQ.size() == 0) begin
          abortRun("dataOk_o pulsed with no request outstanding");
        end else begin
          checkWord(rdData, wordQ.pop_front());
        end
        refilling = 1'b0;
      end
      if ((memRdValid || refilling) && addrOk) begin
        abortRun("addrOk_o went high before the miss completed");
      end
      if (memRdValid && memRdReady) begin
        if (missQ.size() == 0) begin
          abortRun("refill issued where the shadow model predicts a hit");
        end else begin
          checkLine(memAddr, missQ.pop_front());
        end
        refilling = 1'b1;
      end
    end
  end

  initial begin
    #(NumReqs * CyclesPerReq * ClkPeriod);
    abortRun("timeout: the cache stopped answering requests");
  end

  initial begin
    logic [31:0] addr;
    int unsigned tagBits;
    int unsigned setBits;
    int unsigned wordBits;
    cpuValid = 1'b0;
    cpuReq = '0;
    refilling = 1'b0;
    lfsr = 32'h8bad;
    for (int s = 0; s < cachePkg::SETS; s++) begin
      validS[0][s] = 1'b0;
      validS[1][s] = 1'b0;
      lruS[s] = 1'b0;
    end
    @(posedge rst_n);
    if (dataOk || memRdValid || !addrOk) begin
      abortRun($sformatf("FAIL @%0t: handshake outputs not idle after reset", $time));
    end
    // cold miss then each word of the filled line
    issue(32'h0000_1008);
    drain();
    for (int i = 0; i < 4; i++) begin
      issue(32'h0000_1000 + i * 8);
      drain();
    end
    // valid held high for one hit per cycle
    for (int i = 0; i < 16; i++) begin
      issue(32'h0000_1000 + (i % 4) * 8);
    end
    drain();
    // set 5 conflict where C evicts B
    issue(32'h0000_08a0);
    issue(32'h0000_10a0);
    issue(32'h0000_08a8);
    issue(32'h0000_18a0);
    issue(32'h0000_08b0);
    issue(32'h0000_10b8);
    drain();
    // back to back misses under memory stalls
    for (int i = 0; i < 6; i++) begin
      issue(32'h0004_0008 + i * 32);
    end
    drain();
    // random traffic over 8 sets and 8 tags
    for (int i = 0; i < 300; i++) begin
      tagBits = takeBits(3);
      setBits = takeBits(3);
      wordBits = takeBits(2);
      addr = (tagBits << 11) | (setBits << 5) | (wordBits << 3);
      issue(addr);
      if (takeBits(2) == 0) begin
        cpuValid = 1'b0;
        nextCycle();
      end
    end
    drain();
    if (missQ.size() != 0) begin
      abortRun("a refill predicted by the shadow model never happened");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- all.f
hw/cachePkg.sv
hw/cacheSram.sv
hw/cacheWay.sv
hw/refillBuffer.sv
hw/cacheCtrl.sv
hw/cacheTop.sv
dv/tbClock.sv
dv/tbMemModel.sv
dv/cacheTb.sv

//--- Bender.yml
package:
  name: icache2way

sources:
  - hw/cachePkg.sv
  - hw/cacheSram.sv
  - hw/cacheWay.sv
  - hw/refillBuffer.sv
  - hw/cacheCtrl.sv
  - hw/cacheTop.sv
  - target: simulation
    files:
      - dv/tbClock.sv
      - dv/tbMemModel.sv
      - dv/cacheTb.sv
